// File: data_mem_port.sv
`timescale 1ns/1ps

module data_mem_port (
    input  logic                 mem_read_i,
    input  vm_bus_pkg::byte_en_t mem_write_enable_i,
    input  vm_bus_pkg::word_t    mem_read_address_i,
    input  vm_bus_pkg::word_t    mem_write_address_i,

    input  logic                 enable_i,
    input  vm_bus_pkg::word_t    offset_i,
    input  vm_bus_pkg::word_t    size_i,

    output vm_bus_pkg::word_t    mem_address_o,
    output logic                 mem_operation_enable_o,
    output logic                 mem_fault_o
);

    logic              any_write;
    vm_bus_pkg::word_t selected_address;
    vm_bus_pkg::word_t aligned_address;
    logic              data_fault;

    assign any_write = |mem_write_enable_i;

    // store address wins over load address.
    always_comb begin
        if (any_write) begin
            selected_address = mem_write_address_i;
        end
        else begin
            selected_address = mem_read_address_i;
        end
    end

    // word aligned access, byte lanes carry the rest.
    assign aligned_address = {selected_address[vm_bus_pkg::xlen-1:2], 2'b00};

    region_mmu d_mmu (
        .enable_i  (enable_i),
        .offset_i  (offset_i),
        .size_i    (size_i),
        .address_i (aligned_address),
        .address_o (mem_address_o),
        .fault_o   (data_fault)
    );

    // a faulting access never reaches memory.
    assign mem_operation_enable_o = (mem_read_i || any_write) && !data_fault;
    assign mem_fault_o            = data_fault;

endmodule

// File: region_mmu.sv
`timescale 1ns/1ps

module region_mmu (
    input  logic              enable_i,
    input  vm_bus_pkg::word_t offset_i,
    input  vm_bus_pkg::word_t size_i,
    input  vm_bus_pkg::word_t address_i,

    output vm_bus_pkg::word_t address_o,
    output logic              fault_o
);

    vm_bus_pkg::word_t relocated;
    logic              out_of_bounds;

    // base relocation, wraps modulo 2^xlen.
    assign relocated = address_i + offset_i;

    // bound check is made on the virtual address.
    assign out_of_bounds = (address_i >= size_i);

    // pass-through when translation is off.
    always_comb begin
        if (enable_i) begin
            address_o = relocated;
            fault_o   = out_of_bounds;
        end
        else begin
            address_o = address_i;
            fault_o   = 1'b0;
        end
    end

endmodule

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -sv -f tb.f --top-module tb_vm_protect -o tb_vm_protect_sim

# the simulator status is not trusted alone, the log decides.
./obj_dir/tb_vm_protect_sim 2>&1 | tee sim.log || true

if grep -q "Simulation failed" sim.log; then
    echo "run.sh: test failed"
    exit 1
fi
echo "run.sh: test finished without failure"
exit 0

// File: tb.f
vm_csr_pkg.sv
vm_bus_pkg.sv
vm_config_regs.sv
region_mmu.sv
data_mem_port.sv
vm_protect_top.sv
tb_vm_protect.sv

// File: tb_vm_protect.sv
`timescale 1ns/1ps

module tb_vm_protect;

    // keeps addresses near the region sizes so both fault outcomes occur.
    localparam vm_bus_pkg::word_t addr_mask = 32'h1fff_ffff;
    localparam vm_bus_pkg::word_t size_mask = 32'h0fff_ffff;
    localparam int max_cycles = 5000;

    logic                   clk;
    logic                   reset;
    vm_bus_pkg::privilege_e privilege_i;
    logic                   csr_write_i;
    vm_csr_pkg::csr_addr_t  csr_address_i;
    vm_bus_pkg::word_t      csr_write_data_i;
    vm_bus_pkg::word_t      csr_read_data_o;
    vm_bus_pkg::word_t      instruction_address_i;
    vm_bus_pkg::word_t      instruction_address_o;
    logic                   inst_fault_o;
    logic                   mem_read_i;
    vm_bus_pkg::byte_en_t   mem_write_enable_i;
    vm_bus_pkg::word_t      mem_read_address_i;
    vm_bus_pkg::word_t      mem_write_address_i;
    vm_bus_pkg::word_t      mem_address_o;
    logic                   mem_operation_enable_o;
    logic                   mem_fault_o;

    // model of the configuration registers.
    logic              model_ctl;
    vm_bus_pkg::word_t model_do;
    vm_bus_pkg::word_t model_ds;
    vm_bus_pkg::word_t model_io;
    vm_bus_pkg::word_t model_is;

    vm_protect_top vm_protect_top_inst (
        .clk                    (clk),
        .reset                  (reset),
        .privilege_i            (privilege_i),
        .csr_write_i            (csr_write_i),
        .csr_address_i          (csr_address_i),
        .csr_write_data_i       (csr_write_data_i),
        .csr_read_data_o        (csr_read_data_o),
        .instruction_address_i  (instruction_address_i),
        .instruction_address_o  (instruction_address_o),
        .inst_fault_o           (inst_fault_o),
        .mem_read_i             (mem_read_i),
        .mem_write_enable_i     (mem_write_enable_i),
        .mem_read_address_i     (mem_read_address_i),
        .mem_write_address_i    (mem_write_address_i),
        .mem_address_o          (mem_address_o),
        .mem_operation_enable_o (mem_operation_enable_o),
        .mem_fault_o            (mem_fault_o)
    );

    always #4 clk = ~clk;

    task automatic check_word(input string name, input vm_bus_pkg::word_t expected,
                              input vm_bus_pkg::word_t actual);
        if (expected !== actual) begin
            $display("FAIL time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "output word mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (expected !== actual) begin
            $display("FAIL time=%0t %s expected=%b actual=%b", $time, name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "output flag mismatch");
        end
    endtask

    task automatic check_csr(input vm_csr_pkg::csr_addr_t address,
                             input vm_bus_pkg::word_t expected,
                             input vm_bus_pkg::word_t actual);
        if (expected !== actual) begin
            $display("FAIL time=%0t csr_read_data_o[%h] expected=%h actual=%h",
                     $time, address, expected, actual);
            $display("Simulation failed");
            $fatal(1, "csr read-back mismatch");
        end
    endtask

    function automatic vm_bus_pkg::word_t model_read(input vm_csr_pkg::csr_addr_t address);
        case (address)
            12'h7C0: return {31'b0, model_ctl};
            12'h7C1: return model_do;
            12'h7C2: return model_ds;
            12'h7C3: return model_io;
            12'h7C4: return model_is;
            default: return '0;
        endcase
    endfunction

    function automatic void model_write(input vm_csr_pkg::csr_addr_t address,
                                        input vm_bus_pkg::word_t data);
        case (address)
            12'h7C0: model_ctl = data[0];
            12'h7C1: model_do = data;
            12'h7C2: model_ds = data;
            12'h7C3: model_io = data;
            12'h7C4: model_is = data;
            default: begin
            end
        endcase
    endfunction

    // base and bound rule, pass-through when off.
    function automatic void model_translate(input logic on, input vm_bus_pkg::word_t offset,
                                            input vm_bus_pkg::word_t size,
                                            input vm_bus_pkg::word_t address,
                                            output vm_bus_pkg::word_t result,
                                            output logic fault);
        result = on ? address + offset : address;
        fault  = on && (address >= size);
    endfunction

    // called at posedge plus 1 ns, returns at the same phase one cycle later.
    task automatic check_outputs;
        logic              on;
        vm_bus_pkg::word_t selected;
        vm_bus_pkg::word_t exp_inst;
        vm_bus_pkg::word_t exp_mem;
        logic              exp_ifault;
        logic              exp_dfault;
        logic              exp_op;
        @(negedge clk);
        on = model_ctl && (privilege_i != vm_bus_pkg::privilege_machine);
        model_translate(on, model_io, model_is, instruction_address_i, exp_inst, exp_ifault);
        selected = (mem_write_enable_i != 4'b0) ? mem_write_address_i : mem_read_address_i;
        selected[1:0] = 2'b00;
        model_translate(on, model_do, model_ds, selected, exp_mem, exp_dfault);
        exp_op = (mem_read_i || (mem_write_enable_i != 4'b0)) && !exp_dfault;
        check_word("instruction_address_o", exp_inst, instruction_address_o);
        check_flag("inst_fault_o", exp_ifault, inst_fault_o);
        check_word("mem_address_o", exp_mem, mem_address_o);
        check_flag("mem_fault_o", exp_dfault, mem_fault_o);
        check_flag("mem_operation_enable_o", exp_op, mem_operation_enable_o);
        @(posedge clk);
        #1;
    endtask

    // privilege mode 0 any, 1 user or supervisor, 2 machine.
    task automatic drive_random(input int mode);
        vm_bus_pkg::word_t r;
        r = $urandom;
        if (mode == 2 || (mode == 0 && r[1:0] == 2'b11)) begin
            privilege_i = vm_bus_pkg::privilege_machine;
        end
        else if (r[0]) begin
            privilege_i = vm_bus_pkg::privilege_supervisor;
        end
        else begin
            privilege_i = vm_bus_pkg::privilege_user;
        end
        mem_read_i = r[4];
        // half of the accesses carry no byte enable.
        mem_write_enable_i = r[5] ? r[9:6] : 4'b0;
        instruction_address_i = $urandom & addr_mask;
        mem_read_address_i    = $urandom & addr_mask;
        mem_write_address_i   = $urandom & addr_mask;
    endtask

    task automatic csr_write(input vm_csr_pkg::csr_addr_t address,
                             input vm_bus_pkg::word_t data);
        csr_write_i      = 1'b1;
        csr_address_i    = address;
        csr_write_data_i = data;
        @(posedge clk);
        model_write(address, data);
        #1;
        csr_write_i = 1'b0;
        @(negedge clk);
        check_csr(address, model_read(address), csr_read_data_o);
        @(posedge clk);
        #1;
    endtask

    task automatic load_regions;
        csr_write(vm_csr_pkg::csr_mvmdo_addr, $urandom);
        csr_write(vm_csr_pkg::csr_mvmds_addr, $urandom & size_mask);
        csr_write(vm_csr_pkg::csr_mvmio_addr, $urandom);
        csr_write(vm_csr_pkg::csr_mvmis_addr, $urandom & size_mask);
    endtask

    // watchdog against a stuck run.
    initial begin
        for (int cycle = 0; cycle < max_cycles; cycle++) begin
            @(posedge clk);
        end
        $display("timeout: the test sequence did not finish within %0d cycles", max_cycles);
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        vm_bus_pkg::word_t r;
        vm_csr_pkg::csr_addr_t address;
        void'($urandom(32'he543e2fe));
        clk = 1'b0;
        reset = 1'b1;
        privilege_i = vm_bus_pkg::privilege_machine;
        csr_write_i = 1'b0;
        csr_address_i = '0;
        csr_write_data_i = '0;
        instruction_address_i = '0;
        mem_read_i = 1'b0;
        mem_write_enable_i = '0;
        mem_read_address_i = '0;
        mem_write_address_i = '0;
        model_write(vm_csr_pkg::csr_mvmctl_addr, '0);
        model_write(vm_csr_pkg::csr_mvmdo_addr, '0);
        model_write(vm_csr_pkg::csr_mvmds_addr, '0);
        model_write(vm_csr_pkg::csr_mvmio_addr, '0);
        model_write(vm_csr_pkg::csr_mvmis_addr, '0);
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        // pass-through straight after reset.
        for (int i = 0; i < 60; i++) begin
            drive_random(0);
            check_outputs();
        end

        // read-back of known and unknown addresses.
        for (int i = 0; i < 80; i++) begin
            r = $urandom;
            address = r[0] ? (12'h7C0 + 12'(r[3:1] % 5)) : r[15:4];
            csr_write(address, $urandom);
        end

        // user and supervisor with translation on.
        csr_write(vm_csr_pkg::csr_mvmctl_addr, $urandom | 32'h1);
        for (int i = 0; i < 6; i++) begin
            load_regions();
            for (int j = 0; j < 40; j++) begin
                drive_random(1);
                check_outputs();
            end
        end

        // machine mode ignores the control bit.
        for (int i = 0; i < 60; i++) begin
            drive_random(2);
            check_outputs();
        end

        // control bit cleared again.
        csr_write(vm_csr_pkg::csr_mvmctl_addr, $urandom & 32'hffff_fffe);
        for (int i = 0; i < 40; i++) begin
            drive_random(0);
            check_outputs();
        end

        $display("Simulation passed");
        $finish;
    end

endmodule

// File: vm_bus_pkg.sv
package vm_bus_pkg;

    // native register and address width.
    localparam int xlen = 32;

    // addresses, offsets, sizes and csr data.
    typedef logic [xlen-1:0] word_t;

    // one write enable per byte lane.
    typedef logic [xlen/8-1:0] byte_en_t;

    // riscv privilege encoding, hypervisor level unused.
    typedef enum logic [1:0] {
        privilege_user       = 2'b00,
        privilege_supervisor = 2'b01,
        privilege_machine    = 2'b11
    } privilege_e;

endpackage

// File: vm_config_regs.sv
`timescale 1ns/1ps

module vm_config_regs (
    input  logic                   clk,
    input  logic                   reset,

    input  logic                   csr_write_i,
    input  vm_csr_pkg::csr_addr_t  csr_address_i,
    input  vm_bus_pkg::word_t      csr_write_data_i,
    input  vm_bus_pkg::privilege_e privilege_i,

    output vm_bus_pkg::word_t      csr_read_data_o,
    output logic                   mvm_enable_o,
    output vm_bus_pkg::word_t      data_offset_o,
    output vm_bus_pkg::word_t      data_size_o,
    output vm_bus_pkg::word_t      inst_offset_o,
    output vm_bus_pkg::word_t      inst_size_o
);

    logic              mvmctl;
    vm_bus_pkg::word_t mvmdo;
    vm_bus_pkg::word_t mvmds;
    vm_bus_pkg::word_t mvmio;
    vm_bus_pkg::word_t mvmis;

    // register update on write strobe.
    always_ff @(posedge clk) begin
        if (reset) begin
            mvmctl <= 1'b0;
            mvmdo  <= '0;
            mvmds  <= '0;
            mvmio  <= '0;
            mvmis  <= '0;
        end
        else if (csr_write_i) begin
            case (csr_address_i)
                vm_csr_pkg::csr_mvmctl_addr: mvmctl <= csr_write_data_i[0];
                vm_csr_pkg::csr_mvmdo_addr:  mvmdo  <= csr_write_data_i;
                vm_csr_pkg::csr_mvmds_addr:  mvmds  <= csr_write_data_i;
                vm_csr_pkg::csr_mvmio_addr:  mvmio  <= csr_write_data_i;
                vm_csr_pkg::csr_mvmis_addr:  mvmis  <= csr_write_data_i;
                // other addresses are ignored.
                default: begin
                end
            endcase
        end
    end

    // read-back mux, unknown addresses return zero.
    always_comb begin
        case (csr_address_i)
            vm_csr_pkg::csr_mvmctl_addr: begin
                csr_read_data_o = {{(vm_bus_pkg::xlen-1){1'b0}}, mvmctl};
            end
            vm_csr_pkg::csr_mvmdo_addr: csr_read_data_o = mvmdo;
            vm_csr_pkg::csr_mvmds_addr: csr_read_data_o = mvmds;
            vm_csr_pkg::csr_mvmio_addr: csr_read_data_o = mvmio;
            vm_csr_pkg::csr_mvmis_addr: csr_read_data_o = mvmis;
            default:                    csr_read_data_o = '0;
        endcase
    end

    // machine mode always sees physical addresses.
    assign mvm_enable_o = mvmctl && (privilege_i != vm_bus_pkg::privilege_machine);

    assign data_offset_o = mvmdo;
    assign data_size_o   = mvmds;
    assign inst_offset_o = mvmio;
    assign inst_size_o   = mvmis;

endmodule

// File: vm_csr_pkg.sv
package vm_csr_pkg;

    // csr address space of the configuration port.
    localparam int csr_addr_width = 12;

    typedef logic [csr_addr_width-1:0] csr_addr_t;

    // custom machine-level vm registers.
    // control word, only bit 0 is implemented.
    localparam csr_addr_t csr_mvmctl_addr = 12'h7C0;

    // data region base offset.
    localparam csr_addr_t csr_mvmdo_addr  = 12'h7C1;

    // data region size.
    localparam csr_addr_t csr_mvmds_addr  = 12'h7C2;

    // instruction region base offset.
    localparam csr_addr_t csr_mvmio_addr  = 12'h7C3;

    // instruction region size.
    localparam csr_addr_t csr_mvmis_addr  = 12'h7C4;

endpackage

// File: vm_protect_top.sv
`timescale 1ns/1ps

module vm_protect_top (
    input  logic                   clk,
    input  logic                   reset,

    input  vm_bus_pkg::privilege_e privilege_i,

    input  logic                   csr_write_i,
    input  vm_csr_pkg::csr_addr_t  csr_address_i,
    input  vm_bus_pkg::word_t      csr_write_data_i,
    output vm_bus_pkg::word_t      csr_read_data_o,

    input  vm_bus_pkg::word_t      instruction_address_i,
    output vm_bus_pkg::word_t      instruction_address_o,
    output logic                   inst_fault_o,

    input  logic                   mem_read_i,
    input  vm_bus_pkg::byte_en_t   mem_write_enable_i,
    input  vm_bus_pkg::word_t      mem_read_address_i,
    input  vm_bus_pkg::word_t      mem_write_address_i,
    output vm_bus_pkg::word_t      mem_address_o,
    output logic                   mem_operation_enable_o,
    output logic                   mem_fault_o
);

    logic              mvm_enable;
    vm_bus_pkg::word_t data_offset;
    vm_bus_pkg::word_t data_size;
    vm_bus_pkg::word_t inst_offset;
    vm_bus_pkg::word_t inst_size;

    vm_config_regs config_regs (
        .clk              (clk),
        .reset            (reset),
        .csr_write_i      (csr_write_i),
        .csr_address_i    (csr_address_i),
        .csr_write_data_i (csr_write_data_i),
        .privilege_i      (privilege_i),
        .csr_read_data_o  (csr_read_data_o),
        .mvm_enable_o     (mvm_enable),
        .data_offset_o    (data_offset),
        .data_size_o      (data_size),
        .inst_offset_o    (inst_offset),
        .inst_size_o      (inst_size)
    );

    // fetch side translation.
    region_mmu i_mmu (
        .enable_i  (mvm_enable),
        .offset_i  (inst_offset),
        .size_i    (inst_size),
        .address_i (instruction_address_i),
        .address_o (instruction_address_o),
        .fault_o   (inst_fault_o)
    );

    // load/store side translation.
    data_mem_port data_port (
        .mem_read_i             (mem_read_i),
        .mem_write_enable_i     (mem_write_enable_i),
        .mem_read_address_i     (mem_read_address_i),
        .mem_write_address_i    (mem_write_address_i),
        .enable_i               (mvm_enable),
        .offset_i               (data_offset),
        .size_i                 (data_size),
        .mem_address_o          (mem_address_o),
        .mem_operation_enable_o (mem_operation_enable_o),
        .mem_fault_o            (mem_fault_o)
    );

endmodule
